// ==== hw/sync_pkg.sv ====
package sync_pkg;

  // Tree geometry for the 2x2 cluster
  localparam int unsigned N_TILES     = 4;
  localparam int unsigned TREE_LEVELS = 2;  // Leaf height 1, top height 2

  localparam int unsigned LVL_W     = 2;  // Barrier level, 3 overshoots the tree
  localparam int unsigned NODE_ID_W = 2;

  // Node index encoding
  localparam logic [NODE_ID_W-1:0] NODE_LEAF0 = 2'd0;
  localparam logic [NODE_ID_W-1:0] NODE_LEAF1 = 2'd1;
  localparam logic [NODE_ID_W-1:0] NODE_TOP   = 2'd2;
  localparam logic [NODE_ID_W-1:0] NODE_ROOT  = 2'd3;

  localparam int unsigned TS_W = 16;  // Cycle timer width

  // Event port sizing
  localparam int unsigned EVT_DEPTH   = 4;
  localparam int unsigned EVT_CREDITS = 2;

  // One record per wake, 21 bits
  typedef struct packed {
    logic [NODE_ID_W-1:0] node;
    logic [LVL_W-1:0]     level;
    logic                 error;
    logic [TS_W-1:0]      ts;
  } sync_event_t;

endpackage

// ==== hw/print_pkg.sv ====
package print_pkg;

  // Monitored addresses
  localparam logic [31:0] STDERR_ADDR = 32'hFFFF_0000;
  localparam logic [31:0] STDIO_BASE  = 32'hFFFF_0004;  // Plus 4 per tile

  localparam int unsigned TILE_W = 2;  // Low bits of the tile field
  localparam int unsigned ID_W   = 2;
  localparam int unsigned N_IDS  = 2**ID_W;

  // Line buffers
  localparam int unsigned LINE_LEN = 8;
  localparam int unsigned CNT_W    = $clog2(LINE_LEN+1);
  localparam int unsigned IDX_W    = $clog2(LINE_LEN);
  localparam logic [7:0]  NEWLINE  = 8'd10;

  // Character port sizing
  localparam int unsigned CHAR_DEPTH   = 8;
  localparam int unsigned CHAR_CREDITS = 4;

  // 13-bit character record
  typedef struct packed {
    logic [TILE_W-1:0] tile;
    logic [ID_W-1:0]   id;
    logic [7:0]        chr;
    logic              eol;  // Last char of the line
  } print_char_t;

endpackage

// ==== hw/fractal_sync_node.sv ====
`timescale 1ns/1ps

module fractal_sync_node #(
  parameter int unsigned HEIGHT = 1  // 1 for leaf, 2 for top
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [1:0]                    child_sync_i,
  input  logic [1:0][sync_pkg::LVL_W-1:0] child_level_i,
  input  logic [1:0]                    child_ack_i,
  input  logic                          parent_wake_i,
  input  logic                          parent_error_i,
  output logic                          child_wake_o,
  output logic                          child_error_o,
  output logic                          parent_sync_o,
  output logic [sync_pkg::LVL_W-1:0]    parent_level_o,
  output logic                          parent_ack_o,
  output logic                          evt_valid_o,
  output logic [sync_pkg::LVL_W-1:0]    evt_level_o,
  output logic                          evt_error_o
);
  import sync_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FWD,   // Waiting on parent
    ST_WAKE   // Holding wake until both acks
  } state_e;

  state_e           state_q;
  logic             wake_q, err_q;
  logic             from_parent_q;  // Wake came from above
  logic [1:0]       acked_q;
  logic [LVL_W-1:0] lvl_q;
  logic             ack_q, evt_q;
  logic [1:0]       acked_all;

  assign acked_all = acked_q | child_ack_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_IDLE;
      wake_q        <= 1'b0;
      err_q         <= 1'b0;
      from_parent_q <= 1'b0;
      acked_q       <= '0;
      lvl_q         <= '0;
      ack_q         <= 1'b0;
      evt_q         <= 1'b0;
    end else begin
      ack_q <= 1'b0;  // Single-cycle pulses
      evt_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (&child_sync_i) begin
            lvl_q <= child_level_i[0];
            if (child_level_i[0] != child_level_i[1]) begin  // Mismatch
              state_q <= ST_WAKE;
              wake_q  <= 1'b1;
              err_q   <= 1'b1;
              evt_q   <= 1'b1;
            end else if (child_level_i[0] == LVL_W'(HEIGHT)) begin  // Barrier here
              state_q <= ST_WAKE;
              wake_q  <= 1'b1;
              err_q   <= 1'b0;
              evt_q   <= 1'b1;
            end else begin
              state_q <= ST_FWD;  // Goes higher
            end
          end
        end
        ST_FWD: begin
          if (parent_wake_i) begin
            state_q       <= ST_WAKE;
            wake_q        <= 1'b1;
            err_q         <= parent_error_i;
            from_parent_q <= 1'b1;
          end
        end
        default: begin
          acked_q <= acked_all;
          if (&acked_all) begin
            state_q       <= ST_IDLE;
            wake_q        <= 1'b0;
            err_q         <= 1'b0;
            acked_q       <= '0;
            from_parent_q <= 1'b0;
            ack_q         <= from_parent_q;  // Ack upward only if we forwarded
          end
        end
      endcase
    end
  end

  assign child_wake_o   = wake_q;
  assign child_error_o  = err_q;
  // Held until our ack pulse, drops with it
  assign parent_sync_o  = (state_q == ST_FWD) || (state_q == ST_WAKE && from_parent_q);
  assign parent_level_o = lvl_q;
  assign parent_ack_o   = ack_q;
  assign evt_valid_o    = evt_q;
  assign evt_level_o    = lvl_q;
  assign evt_error_o    = err_q;

  // Children must still hold sync when wake rises
  a_wake_needs_sync: assert property (
    @(posedge clk) disable iff (!rst_n_i) $rose(child_wake_o) |-> &child_sync_i
  );

endmodule

// ==== hw/sync_tree.sv ====
`timescale 1ns/1ps

module sync_tree (
  input  logic                                               clk,
  input  logic                                               rst_n_i,
  input  logic [sync_pkg::N_TILES-1:0]                       sync_i,
  input  logic [sync_pkg::N_TILES-1:0][sync_pkg::LVL_W-1:0]  level_i,
  input  logic [sync_pkg::N_TILES-1:0]                       ack_i,
  output logic [sync_pkg::N_TILES-1:0]                       wake_o,
  output logic [sync_pkg::N_TILES-1:0]                       error_o,
  output logic                                               evt_valid_o,
  output sync_pkg::sync_event_t                              evt_data_o,
  input  logic                                               evt_ready_i
);
  import sync_pkg::*;

  localparam int unsigned N_SRC = 4;  // Two leaves, top, root

  // Leaf to top wiring
  logic [1:0]            leaf_sync, leaf_ack;
  logic [1:0][LVL_W-1:0] leaf_level;
  logic                  top_wake, top_err;

  // Top to root wiring
  logic             root_sync, root_ack;
  logic [LVL_W-1:0] root_level;
  logic             root_pend_q, root_wake_q, root_evt_q;  // Root responder state

  // Per-source event taps
  logic [N_SRC-1:0]            src_valid, src_error;
  logic [N_SRC-1:0][LVL_W-1:0] src_level;

  logic [TS_W-1:0] ts_q;  // Free-running timer

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) ts_q <= '0;
    else          ts_q <= ts_q + 1'b1;
  end

  for (genvar i = 0; i < 2; i++) begin : gen_leaf
    fractal_sync_node #(.HEIGHT(1)) i_leaf (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .child_sync_i  (sync_i[2*i+1 -: 2]),
      .child_level_i (level_i[2*i+1 -: 2]),
      .child_ack_i   (ack_i[2*i+1 -: 2]),
      .parent_wake_i (top_wake),
      .parent_error_i(top_err),
      .child_wake_o  (wake_o[2*i]),
      .child_error_o (error_o[2*i]),
      .parent_sync_o (leaf_sync[i]),
      .parent_level_o(leaf_level[i]),
      .parent_ack_o  (leaf_ack[i]),
      .evt_valid_o   (src_valid[i]),
      .evt_level_o   (src_level[i]),
      .evt_error_o   (src_error[i])
    );
    assign wake_o[2*i+1]  = wake_o[2*i];  // Both tiles of a pair share the wake
    assign error_o[2*i+1] = error_o[2*i];
  end

  fractal_sync_node #(.HEIGHT(TREE_LEVELS)) i_top (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .child_sync_i  (leaf_sync),
    .child_level_i (leaf_level),
    .child_ack_i   (leaf_ack),
    .parent_wake_i (root_wake_q),
    .parent_error_i(root_wake_q),  // Root only ever answers with error
    .child_wake_o  (top_wake),
    .child_error_o (top_err),
    .parent_sync_o (root_sync),
    .parent_level_o(root_level),
    .parent_ack_o  (root_ack),
    .evt_valid_o   (src_valid[2]),
    .evt_level_o   (src_level[2]),
    .evt_error_o   (src_error[2])
  );

  // Root responder, wake two cycles after sync
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      root_pend_q <= 1'b0;
      root_wake_q <= 1'b0;
      root_evt_q  <= 1'b0;
    end else begin
      root_evt_q <= 1'b0;
      if (root_wake_q) begin
        if (root_ack) root_wake_q <= 1'b0;
      end else if (root_pend_q) begin
        root_pend_q <= 1'b0;
        root_wake_q <= 1'b1;
        root_evt_q  <= 1'b1;
      end else if (root_sync) begin
        root_pend_q <= 1'b1;
      end
    end
  end

  assign src_valid[3] = root_evt_q;
  assign src_level[3] = root_level;
  assign src_error[3] = 1'b1;

  // One hold slot per source, lowest index drains first
  logic [N_SRC-1:0] pend_q;
  sync_event_t      rec_q [N_SRC];
  logic [N_SRC-1:0] sel;

  always_comb begin
    sel = '0;
    for (int i = N_SRC-1; i >= 0; i--) begin
      if (pend_q[i]) sel = N_SRC'(1) << i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~(evt_ready_i ? sel : '0)) | src_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_SRC; i++) begin
      if (src_valid[i]) begin
        rec_q[i] <= '{node: NODE_ID_W'(i), level: src_level[i],
                      error: src_error[i], ts: ts_q};  // Wake cycle stamp
      end
    end
  end

  always_comb begin
    evt_data_o = rec_q[0];
    for (int i = 0; i < N_SRC; i++) begin
      if (sel[i]) evt_data_o = rec_q[i];
    end
  end

  assign evt_valid_o = (|pend_q) && evt_ready_i;

endmodule

// ==== hw/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4,  // Power of two
  parameter int unsigned CREDITS   = 2
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     credit_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH+1);
  localparam int unsigned CRD_W = $clog2(CREDITS+1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] credit_q;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0) && (credit_q != '0);  // Needs entry and credit
  assign pop     = valid_o;
  assign data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= CRD_W'(CREDITS);
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
      if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop);
      credit_q <= credit_q + CRD_W'(credit_i) - CRD_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n_i) push_i |-> ready_o
  );
  // Last credit spent and none returned, port goes quiet
  a_no_valid_no_credit: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      valid_o && credit_q == CRD_W'(1) && !credit_i |=> !valid_o
  );

endmodule

// ==== hw/stdout_capture.sv ====
`timescale 1ns/1ps

module stdout_capture (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     aw_valid_i,
  input  logic [31:0]              aw_addr_i,
  input  logic [print_pkg::ID_W-1:0] aw_id_i,
  input  logic                     w_valid_i,
  input  logic [7:0]               w_data_i,
  input  logic                     char_ready_i,
  output logic                     char_push_o,
  output print_pkg::print_char_t   char_data_o,
  output logic [7:0]               err_count_o,
  output logic                     err_valid_o
);
  import print_pkg::*;

  // Address decode
  logic [31:0] off;
  logic        is_stdio, is_stderr;

  assign off       = aw_addr_i - STDIO_BASE;
  assign is_stderr = (aw_addr_i == STDERR_ADDR);
  assign is_stdio  = (off[31:4] == '0) && (off[1:0] == 2'b00);  // Four tile slots

  // Pending address beat
  logic              pend_io_q, pend_err_q;
  logic [ID_W-1:0]   pend_id_q;
  logic [TILE_W-1:0] pend_tile_q;

  // Line buffers, one per ID
  logic [7:0]        buf_q  [N_IDS][LINE_LEN];
  logic [TILE_W-1:0] tile_q [N_IDS];
  logic [CNT_W-1:0]  cnt_q  [N_IDS];
  logic [N_IDS-1:0]  done_q;  // Line ready to flush

  // Flush control
  logic            fl_act_q;
  logic [ID_W-1:0] fl_id_q;
  logic [IDX_W-1:0] fl_idx_q;
  logic [ID_W-1:0] cur_id;
  logic [IDX_W-1:0] cur_idx;
  logic            cur_last, append;

  // Lowest complete ID unless a line is mid-flight
  always_comb begin
    cur_id = fl_id_q;
    if (!fl_act_q) begin
      for (int i = N_IDS-1; i >= 0; i--) begin
        if (done_q[i]) cur_id = ID_W'(i);
      end
    end
  end

  assign cur_idx     = fl_act_q ? fl_idx_q : '0;
  assign cur_last    = (CNT_W'(cur_idx) == cnt_q[cur_id] - 1'b1);
  assign char_push_o = (fl_act_q || (|done_q)) && char_ready_i;  // Stall on full FIFO
  assign char_data_o = '{tile: tile_q[cur_id], id: cur_id,
                         chr: buf_q[cur_id][cur_idx], eol: cur_last};

  // Drop beats into a full or finished line
  assign append = w_valid_i && pend_io_q && !done_q[pend_id_q];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_io_q   <= 1'b0;
      pend_err_q  <= 1'b0;
      pend_id_q   <= '0;
      pend_tile_q <= '0;
      done_q      <= '0;
      fl_act_q    <= 1'b0;
      fl_id_q     <= '0;
      fl_idx_q    <= '0;
      err_valid_o <= 1'b0;
      err_count_o <= '0;
      for (int i = 0; i < N_IDS; i++) cnt_q[i] <= '0;
    end else begin
      if (aw_valid_i) begin
        pend_err_q <= is_stderr;
        pend_io_q  <= is_stdio;
        if (is_stdio) begin
          pend_id_q   <= aw_id_i;
          pend_tile_q <= off[3:2];
        end
      end
      if (w_valid_i && pend_err_q) begin  // Stderr latch
        err_count_o <= w_data_i;
        err_valid_o <= 1'b1;
        pend_err_q  <= 1'b0;
      end
      if (w_valid_i && pend_io_q) begin
        pend_io_q <= 1'b0;  // One data beat per address beat
      end
      if (append) begin
        cnt_q[pend_id_q] <= cnt_q[pend_id_q] + 1'b1;
        if (w_data_i == NEWLINE || cnt_q[pend_id_q] == CNT_W'(LINE_LEN-1))
          done_q[pend_id_q] <= 1'b1;
      end
      if (char_push_o) begin
        if (cur_last) begin
          fl_act_q       <= 1'b0;
          done_q[cur_id] <= 1'b0;  // Buffer free again
          cnt_q[cur_id]  <= '0;
        end else begin
          fl_act_q <= 1'b1;
          fl_id_q  <= cur_id;
          fl_idx_q <= cur_idx + 1'b1;
        end
      end
    end
  end

  // Character storage
  always_ff @(posedge clk) begin
    if (append) begin
      buf_q[pend_id_q][cnt_q[pend_id_q][IDX_W-1:0]] <= w_data_i;
      tile_q[pend_id_q] <= pend_tile_q;
    end
  end

endmodule

// ==== hw/mesh_monitor_top.sv ====
`timescale 1ns/1ps

module mesh_monitor_top (
  input  logic                                               clk,
  input  logic                                               rst_n_i,
  input  logic [sync_pkg::N_TILES-1:0]                       sync_i,
  input  logic [sync_pkg::N_TILES-1:0][sync_pkg::LVL_W-1:0]  level_i,
  input  logic [sync_pkg::N_TILES-1:0]                       ack_i,
  output logic [sync_pkg::N_TILES-1:0]                       wake_o,
  output logic [sync_pkg::N_TILES-1:0]                       error_o,
  input  logic                                               aw_valid_i,
  input  logic [31:0]                                        aw_addr_i,
  input  logic [print_pkg::ID_W-1:0]                         aw_id_i,
  input  logic                                               w_valid_i,
  input  logic [7:0]                                         w_data_i,
  output logic                                               evt_valid_o,
  output sync_pkg::sync_event_t                              evt_data_o,
  input  logic                                               evt_credit_i,
  output logic                                               char_valid_o,
  output print_pkg::print_char_t                             char_data_o,
  input  logic                                               char_credit_i,
  output logic [7:0]                                         err_count_o,
  output logic                                               err_valid_o
);
  import sync_pkg::*;
  import print_pkg::*;

  logic        evt_push, evt_ready;
  sync_event_t evt_rec;
  logic        char_push, char_ready;
  print_char_t char_rec;

  sync_tree i_sync_tree (
    .clk(clk), .rst_n_i(rst_n_i),
    .sync_i(sync_i), .level_i(level_i), .ack_i(ack_i),
    .wake_o(wake_o), .error_o(error_o),
    .evt_valid_o(evt_push), .evt_data_o(evt_rec), .evt_ready_i(evt_ready)
  );

  stdout_capture i_stdout_capture (
    .clk(clk), .rst_n_i(rst_n_i),
    .aw_valid_i(aw_valid_i), .aw_addr_i(aw_addr_i), .aw_id_i(aw_id_i),
    .w_valid_i(w_valid_i), .w_data_i(w_data_i), .char_ready_i(char_ready),
    .char_push_o(char_push), .char_data_o(char_rec),
    .err_count_o(err_count_o), .err_valid_o(err_valid_o)
  );

  // Event stream out
  credit_fifo #(.payload_t(sync_event_t), .DEPTH(EVT_DEPTH), .CREDITS(EVT_CREDITS))
  i_evt_fifo (
    .clk(clk), .rst_n_i(rst_n_i), .push_i(evt_push), .data_i(evt_rec),
    .ready_o(evt_ready), .valid_o(evt_valid_o), .data_o(evt_data_o),
    .credit_i(evt_credit_i)
  );

  // Line stream out
  credit_fifo #(.payload_t(print_char_t), .DEPTH(CHAR_DEPTH), .CREDITS(CHAR_CREDITS))
  i_char_fifo (
    .clk(clk), .rst_n_i(rst_n_i), .push_i(char_push), .data_i(char_rec),
    .ready_o(char_ready), .valid_o(char_valid_o), .data_o(char_data_o),
    .credit_i(char_credit_i)
  );

endmodule

// ==== dv/tb_mesh_monitor.sv ====
`timescale 1ns/1ps

module tb_mesh_monitor;
  import sync_pkg::*;
  import print_pkg::*;

  localparam string CMD_FILE  = "dv/mesh_monitor_input.txt";
  localparam int    DRIVE_DLY = 2;  // ns after the rising edge

  logic                          clk, rst_n;
  logic [N_TILES-1:0]            tile_sync, tile_ack, tile_wake, tile_error;
  logic [N_TILES-1:0][LVL_W-1:0] tile_level;
  logic                          aw_valid, w_valid;
  logic [31:0]                   aw_addr;
  logic [ID_W-1:0]               aw_id;
  logic [7:0]                    w_data, err_count;
  logic                          evt_valid, evt_credit, char_valid, char_credit, err_valid;
  sync_event_t                   evt_data;
  print_char_t                   char_data;

  // Bookkeeping
  int unsigned cycles, cycle_limit;
  int unsigned checks, errors, test_errors, tests_run, tests_failed;
  string       test_name = "";
  string       cmds[$];
  sync_event_t obs_evt[$];   // Records seen on the ports, in order
  print_char_t obs_char[$];
  int          evt_crd  = EVT_CREDITS;  // Mirror of the DUT credit counters
  int          char_crd = CHAR_CREDITS;
  bit          crd_hold;
  int unsigned evt_held, char_held;
  logic [7:0]  lfsr = 8'd14;
  logic [TS_W-1:0] last_ts;
  bit          ts_seen;

  mesh_monitor_top i_mesh_monitor_top (
    .clk(clk), .rst_n_i(rst_n),
    .sync_i(tile_sync), .level_i(tile_level), .ack_i(tile_ack),
    .wake_o(tile_wake), .error_o(tile_error),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_id_i(aw_id),
    .w_valid_i(w_valid), .w_data_i(w_data),
    .evt_valid_o(evt_valid), .evt_data_o(evt_data), .evt_credit_i(evt_credit),
    .char_valid_o(char_valid), .char_data_o(char_data), .char_credit_i(char_credit),
    .err_count_o(err_count), .err_valid_o(err_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // Galois form, taps for x^8+x^6+x^5+x^4+1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] expd, input string what);
    checks++;
    assert (got === expd) else begin
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, expd);
      errors++;
      test_errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("[ERROR] %0d ns: %s", $time, what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      if (test_errors == 0) begin
        $display("[TEST] %s: ok", test_name);
      end else begin
        $display("[TEST] %s: %0d errors", test_name, test_errors);
        tests_failed++;
      end
    end
  endtask

  task automatic start_test(input string name);
    finish_test();
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  // Random credit return, one LFSR step per port and cycle
  initial begin : credit_return
    evt_credit  = 1'b0;
    char_credit = 1'b0;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      lfsr = lfsr_next(lfsr);
      evt_credit = rst_n && !crd_hold && (evt_crd < int'(EVT_CREDITS)) && lfsr[0];
      lfsr = lfsr_next(lfsr);
      char_credit = rst_n && !crd_hold && (char_crd < int'(CHAR_CREDITS)) && lfsr[0];
    end
  end

  // Port monitor, outputs settled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (evt_valid) begin
        expect_true(evt_crd > 0, "event record presented without a credit");
        obs_evt.push_back(evt_data);
        if (crd_hold) evt_held++;
      end
      if (char_valid) begin
        expect_true(char_crd > 0, "character presented without a credit");
        obs_char.push_back(char_data);
        if (crd_hold) char_held++;
      end
      evt_crd  = evt_crd - int'(evt_valid) + int'(evt_credit);  // Pulse counts at next edge
      char_crd = char_crd - int'(char_valid) + int'(char_credit);
    end
  end

  task automatic tile_barrier(input logic [N_TILES-1:0][LVL_W-1:0] lvl,
                              input logic [N_TILES-1:0] mask, exp_wake, exp_err);
    @(posedge clk);
    #DRIVE_DLY;
    tile_level = lvl;
    tile_sync  = mask;
    @(negedge clk);
    while ((tile_wake & mask) != mask) @(negedge clk);
    expect_eq(tile_wake, exp_wake, "wake");
    expect_eq(tile_error, exp_err, "error");
    @(posedge clk);
    #DRIVE_DLY;
    tile_ack  = mask;  // Sync drops in the ack cycle
    tile_sync = '0;
    @(posedge clk);
    #DRIVE_DLY;
    tile_ack = '0;
    @(negedge clk);
    expect_eq(tile_wake, '0, "wake after ack");
  endtask

  // Address beat, then its data beat
  task automatic write_beat(input logic [31:0] addr, input logic [ID_W-1:0] id,
                            input logic [7:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    aw_valid = 1'b1;
    aw_addr  = addr;
    aw_id    = id;
    @(posedge clk);
    #DRIVE_DLY;
    aw_valid = 1'b0;
    w_valid  = 1'b1;
    w_data   = data;
    @(posedge clk);
    #DRIVE_DLY;
    w_valid = 1'b0;
  endtask

  task automatic write_text(input int id, input int tile, input string text, input int nl);
    logic [31:0] addr;
    addr = STDIO_BASE + 32'(4 * tile);  // One word per tile
    for (int i = 0; i < text.len(); i++) write_beat(addr, ID_W'(id), text[i]);
    if (nl != 0) write_beat(addr, ID_W'(id), NEWLINE);
  endtask

  task automatic expect_char(input int id, input int tile, input logic [7:0] chr,
                             input bit eol);
    print_char_t rec;
    while (obs_char.size() == 0) @(posedge clk);
    rec = obs_char.pop_front();
    expect_eq(rec.id, id, "line id");
    expect_eq(rec.tile, tile, "line tile");
    expect_eq(rec.chr, chr, "line character");
    expect_eq(rec.eol, eol, "end-of-line flag");
  endtask

  task automatic expect_line(input int id, input int tile, input string text, input int nl);
    for (int i = 0; i < text.len(); i++) begin
      expect_char(id, tile, text[i], nl == 0 && i == text.len() - 1);
    end
    if (nl != 0) expect_char(id, tile, NEWLINE, 1'b1);
  endtask

  task automatic expect_event(input int node, input int level, input int err);
    sync_event_t rec;
    while (obs_evt.size() == 0) @(posedge clk);
    rec = obs_evt.pop_front();
    expect_eq(rec.node, node, "event node");
    expect_eq(rec.level, level, "event level");
    expect_eq(rec.error, err, "event error");
    expect_true(!ts_seen || rec.ts > last_ts, "event timestamp did not increase");
    last_ts = rec.ts;
    ts_seen = 1'b1;
  endtask

  // Mid-cycle change, away from monitor and credit timing
  task automatic set_credit_hold(input bit hold);
    @(posedge clk);
    #1;
    if (hold) begin
      evt_held  = 0;
      char_held = 0;
    end else begin
      expect_true(evt_held <= EVT_CREDITS, "more events than credits while credits were held");
      expect_true(char_held <= CHAR_CREDITS, "more characters than credits while held");
    end
    crd_hold = hold;
  endtask

  task automatic run_command(input string line);
    string       op, text;
    int          a, b, c, d, n;
    logic [31:0] m, w, e;
    case (line.getc(0))
      "T": begin
        n = $sscanf(line, "%s %s", op, text);
        start_test(text);
      end
      "S": begin
        n = $sscanf(line, "%s %d %d %d %d %h %h %h", op, a, b, c, d, m, w, e);
        tile_barrier({LVL_W'(d), LVL_W'(c), LVL_W'(b), LVL_W'(a)},
                     N_TILES'(m), N_TILES'(w), N_TILES'(e));
      end
      "W", "L": begin
        n = $sscanf(line, "%s %d %d %s %d", op, a, b, text, c);
        if (line.getc(0) == "W") write_text(a, b, text, c);
        else expect_line(a, b, text, c);
      end
      "E": begin
        n = $sscanf(line, "%s %d %d %d", op, a, b, c);
        expect_event(a, b, c);
      end
      "R": begin
        n = $sscanf(line, "%s %h", op, m);
        write_beat(STDERR_ADDR, '0, m[7:0]);
        @(negedge clk);
        expect_eq(err_valid, 1'b1, "stderr valid");
        expect_eq(err_count, m[7:0], "stderr count");
      end
      "H": begin
        n = $sscanf(line, "%s %d", op, a);
        set_credit_hold(a == 0);
      end
      "D": begin
        n = $sscanf(line, "%s %d", op, a);
        repeat (a) @(posedge clk);
      end
      default: expect_true(1'b0, {"unknown command in input file: ", line});
    endcase
  endtask

  task automatic load_commands(output bit ok);
    int    fd, r;
    string line;
    fd = $fopen(CMD_FILE, "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 1 && line.getc(0) != "#") cmds.push_back(line);  // Skip notes and blanks
      end
      $fclose(fd);
      cycle_limit = 40 * cmds.size() + 200;
    end
  endtask

  initial begin : main
    bit ok;
    rst_n      = 1'b0;
    tile_sync  = '0;
    tile_ack   = '0;
    tile_level = '0;
    aw_valid   = 1'b0;
    aw_addr    = '0;
    aw_id      = '0;
    w_valid    = 1'b0;
    w_data     = '0;
    load_commands(ok);
    if (!ok) begin
      $display("Could not open the command file %s", CMD_FILE);
      $display("test failed");
      $finish;
    end else begin
      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      start_test("reset_state");
      @(negedge clk);
      expect_eq(tile_wake, '0, "wake after reset");
      expect_eq(tile_error, '0, "error after reset");
      expect_eq({evt_valid, char_valid, err_valid}, '0, "valid flags after reset");
      foreach (cmds[i]) run_command(cmds[i]);
      start_test("drain");  // Nothing unexpected may follow
      repeat (20) @(posedge clk);
      expect_eq(obs_evt.size(), 0, "events left over");
      expect_eq(obs_char.size(), 0, "characters left over");
      finish_test();
      $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

// ==== dv/mesh_monitor_input.txt ====
# T name | S lvl0 lvl1 lvl2 lvl3 sync_mask wake_mask err_mask | E node level err
# W/L id tile text newline | R stderr_data | H credits_on | D cycles
T pair_barrier
S 1 1 0 0 3 3 0
E 0 1 0
T full_barrier
S 2 2 2 2 f f 0
E 2 2 0
T errors
S 1 2 0 0 3 3 3
E 0 1 1
S 3 3 3 3 f f f
E 3 3 1
S 2 2 3 3 f f f
E 2 2 1
T line_reassembly
W 0 0 Hel 0
W 1 2 wor 0
W 0 0 lo 1
W 1 2 ld 1
L 0 0 Hello 1
L 1 2 world 1
W 3 1 abcdefgh 0
L 3 1 abcdefgh 0
T credit_backpressure
H 0
S 2 2 2 2 f f 0
S 0 0 1 1 c c 0
S 1 2 0 0 3 3 3
W 2 3 pqrs 1
D 30
H 1
E 2 2 0
E 1 1 0
E 0 1 1
L 2 3 pqrs 1
T stderr
R 5a
R 3c

// ==== sources.f ====
hw/sync_pkg.sv
hw/print_pkg.sv
hw/fractal_sync_node.sv
hw/sync_tree.sv
hw/credit_fifo.sv
hw/stdout_capture.sv
hw/mesh_monitor_top.sv
dv/tb_mesh_monitor.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mesh monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_mesh_monitor \
  -Mdir obj_dir -o sim_mesh_monitor
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_mesh_monitor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
